// ==== include/noc_config.svh ====
// NoC configuration
// Mesh geometry, field widths and per-input buffer depth
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Mesh dimensions
`define NOC_NUM_ROWS 2
`define NOC_NUM_COLS 2

`define NOC_FLIT_WIDTH 32
`define NOC_COORD_WIDTH 1

// Input FIFO entries, also the starting credit count of a sender
`define NOC_BUFFER_DEPTH 4

// Local port plus four mesh directions
`define NOC_NUM_PORTS 5

`endif

// ==== logic/noc_flit_pkg.sv ====
// Flit field types
// Payload, destination node number and credit counter widths
`include "noc_config.svh"

package noc_flit_pkg;

    // Payload carried by every flit
    typedef logic [`NOC_FLIT_WIDTH-1:0] flit_data_t;

    // Node number is row * columns + column
    typedef logic [$clog2(`NOC_NUM_ROWS * `NOC_NUM_COLS)-1:0] node_id_t;

    // Holds 0 up to the buffer depth
    typedef logic [$clog2(`NOC_BUFFER_DEPTH + 1)-1:0] credit_count_t;

endpackage

// ==== logic/noc_route_pkg.sv ====
// Routing types and XY route computation
// Port directions, one-hot port masks and mesh coordinates
`include "noc_config.svh"

package noc_route_pkg;
    import noc_flit_pkg::*;

    typedef enum logic [2:0] {
        DIR_LOCAL = 3'd0,
        DIR_NORTH = 3'd1,
        DIR_SOUTH = 3'd2,
        DIR_EAST  = 3'd3,
        DIR_WEST  = 3'd4
    } port_dir_e;

    // One bit per port, indexed by port_dir_e
    typedef logic [`NOC_NUM_PORTS-1:0] port_mask_t;

    typedef logic [`NOC_COORD_WIDTH-1:0] coord_t;

    // Column corrected first, then row
    function automatic port_dir_e xy_route(coord_t row, coord_t col, node_id_t dest);
        coord_t dest_row;
        coord_t dest_col;
        dest_row = coord_t'(dest / `NOC_NUM_COLS);
        dest_col = coord_t'(dest % `NOC_NUM_COLS);
        if (dest_col > col) begin
            return DIR_EAST;
        end else if (dest_col < col) begin
            return DIR_WEST;
        end else if (dest_row > row) begin
            return DIR_SOUTH;
        end else if (dest_row < row) begin
            return DIR_NORTH;
        end
        return DIR_LOCAL;
    endfunction

endpackage

// ==== logic/noc_input_unit.sv ====
// Router input unit
// Buffers incoming flits, computes the XY route of each packet head
// and returns one credit for every flit that leaves the buffer
`timescale 1ns/1ps
`include "noc_config.svh"

module noc_input_unit
    import noc_flit_pkg::*, noc_route_pkg::*;
#(
    parameter int ROW = 0,
    parameter int COL = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  flit_data_t data,
    input  node_id_t   dest,
    input  logic       is_tail,
    input  logic       send,
    input  logic       grant,
    output flit_data_t head_data,
    output node_id_t   head_dest,
    output logic       head_tail,
    output logic       head_valid,
    output port_mask_t route_req,
    output logic       credit
);

    localparam int DEPTH = `NOC_BUFFER_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    flit_data_t mem_data [DEPTH];
    node_id_t   mem_dest [DEPTH];
    logic       mem_tail [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_count_t    count;
    logic             pop;

    logic      in_packet;
    port_dir_e route_q;
    port_dir_e route_cur;

    assign head_valid = (count != '0);
    assign head_data  = mem_data[rd_ptr];
    assign head_dest  = mem_dest[rd_ptr];
    assign head_tail  = mem_tail[rd_ptr];
    assign pop        = grant & head_valid;

    always_ff @(posedge clk) begin
        if (send) begin
            mem_data[wr_ptr] <= data;
            mem_dest[wr_ptr] <= dest;
            mem_tail[wr_ptr] <= is_tail;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (send) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count  <= count + credit_count_t'(send) - credit_count_t'(pop);
            credit <= pop;
        end
    end

    // Body flits follow the route taken by their head
    assign route_cur = in_packet ? route_q : xy_route(coord_t'(ROW), coord_t'(COL), head_dest);
    assign route_req = head_valid ? port_mask_t'(1 << route_cur) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_packet <= 1'b0;
            route_q   <= DIR_LOCAL;
        end else if (pop) begin
            in_packet <= !head_tail;
            route_q   <= route_cur;
        end
    end

    // Upstream credit counting keeps the FIFO from overflowing
    assert property (@(posedge clk) disable iff (!rst_n)
        send |-> count != credit_count_t'(DEPTH));

    // Ejection only at the node the packet is addressed to
    assert property (@(posedge clk) disable iff (!rst_n)
        route_req[DIR_LOCAL] |-> head_dest == node_id_t'(ROW * `NOC_NUM_COLS + COL));

endmodule

// ==== logic/noc_switch_allocator.sv ====
// Switch allocator
// Round-robin arbitration for each output, with wormhole locking that
// keeps an output on one input until that input's tail flit passes
`timescale 1ns/1ps
`include "noc_config.svh"

module noc_switch_allocator
    import noc_route_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  port_mask_t                route_req [`NOC_NUM_PORTS],
    input  logic [`NOC_NUM_PORTS-1:0] head_valid,
    input  logic [`NOC_NUM_PORTS-1:0] head_tail,
    input  port_mask_t                out_ready,
    output logic [`NOC_NUM_PORTS-1:0] grant,
    output port_dir_e                 out_select [`NOC_NUM_PORTS],
    output port_mask_t                out_fire
);

    localparam int N = `NOC_NUM_PORTS;

    logic       lock_q  [N];
    port_dir_e  owner_q [N];
    port_dir_e  rr_q    [N];
    // Requests seen by each output, indexed by input
    port_mask_t req_vec [N];

    always_comb begin
        for (int o = 0; o < N; o++) begin
            for (int i = 0; i < N; i++) begin
                req_vec[o][i] = route_req[i][o] & head_valid[i];
            end
        end
    end

    always_comb begin
        int   idx;
        logic found;
        idx      = 0;
        grant    = '0;
        out_fire = '0;
        for (int o = 0; o < N; o++) begin
            found         = 1'b0;
            out_select[o] = owner_q[o];
            if (lock_q[o]) begin
                found = req_vec[o][owner_q[o]];
            end else begin
                // Search starts one past the last winner
                for (int k = 1; k <= N; k++) begin
                    idx = (int'(rr_q[o]) + k) % N;
                    if (!found && req_vec[o][idx]) begin
                        found         = 1'b1;
                        out_select[o] = port_dir_e'(idx[2:0]);
                    end
                end
            end
            out_fire[o] = found & out_ready[o];
            if (out_fire[o]) begin
                grant[out_select[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int o = 0; o < N; o++) begin
                lock_q[o]  <= 1'b0;
                owner_q[o] <= DIR_LOCAL;
                rr_q[o]    <= DIR_WEST;
            end
        end else begin
            for (int o = 0; o < N; o++) begin
                if (out_fire[o]) begin
                    lock_q[o]  <= !head_tail[out_select[o]];
                    owner_q[o] <= out_select[o];
                    rr_q[o]    <= out_select[o];
                end
            end
        end
    end

    for (genvar o = 0; o < N; o++) begin : g_chk
        // At most one input wins each output
        assert property (@(posedge clk) disable iff (!rst_n)
            $onehot0(grant & req_vec[o]));
    end

endmodule

// ==== logic/noc_output_unit.sv ====
// Router output unit
// Registers the flit picked by the crossbar onto the link and
// tracks the credits left in the downstream buffer
`timescale 1ns/1ps
`include "noc_config.svh"

module noc_output_unit
    import noc_flit_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       fire,
    input  flit_data_t xbar_data,
    input  node_id_t   xbar_dest,
    input  logic       xbar_tail,
    input  logic       credit,
    output flit_data_t data,
    output node_id_t   dest,
    output logic       is_tail,
    output logic       send,
    output logic       ready
);

    localparam credit_count_t MAX_CREDITS = credit_count_t'(`NOC_BUFFER_DEPTH);

    credit_count_t credits;

    always_ff @(posedge clk) begin
        if (fire) begin
            data    <= xbar_data;
            dest    <= xbar_dest;
            is_tail <= xbar_tail;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            send    <= 1'b0;
            credits <= MAX_CREDITS;
        end else begin
            send    <= fire;
            credits <= credits - credit_count_t'(fire) + credit_count_t'(credit);
        end
    end

    assign ready = (credits != '0);

    // Downstream never returns more credits than flits it was sent
    assert property (@(posedge clk) disable iff (!rst_n)
        credits <= MAX_CREDITS);

endmodule

// ==== logic/noc_router.sv ====
// Five-port mesh router
// Input units, switch allocator, crossbar and output units for the
// router at (ROW, COL); ports facing the mesh edge are not built
`timescale 1ns/1ps
`include "noc_config.svh"

module noc_router
    import noc_flit_pkg::*, noc_route_pkg::*;
#(
    parameter int ROW = 0,
    parameter int COL = 0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  flit_data_t data_in     [`NOC_NUM_PORTS],
    input  node_id_t   dest_in     [`NOC_NUM_PORTS],
    input  logic       is_tail_in  [`NOC_NUM_PORTS],
    input  logic       send_in     [`NOC_NUM_PORTS],
    output logic       credit_out  [`NOC_NUM_PORTS],
    output flit_data_t data_out    [`NOC_NUM_PORTS],
    output node_id_t   dest_out    [`NOC_NUM_PORTS],
    output logic       is_tail_out [`NOC_NUM_PORTS],
    output logic       send_out    [`NOC_NUM_PORTS],
    input  logic       credit_in   [`NOC_NUM_PORTS]
);

    localparam int N = `NOC_NUM_PORTS;

    flit_data_t   head_data  [N];
    node_id_t     head_dest  [N];
    logic [N-1:0] head_tail;
    logic [N-1:0] head_valid;
    port_mask_t   route_req  [N];
    logic [N-1:0] grant;
    port_dir_e    out_select [N];
    port_mask_t   out_fire;
    port_mask_t   out_ready;
    flit_data_t   xbar_data  [N];
    node_id_t     xbar_dest  [N];
    logic         xbar_tail  [N];

    // Crossbar, one mux per output
    always_comb begin
        for (int o = 0; o < N; o++) begin
            xbar_data[o] = head_data[out_select[o]];
            xbar_dest[o] = head_dest[out_select[o]];
            xbar_tail[o] = head_tail[out_select[o]];
        end
    end

    for (genvar p = 0; p < N; p++) begin : g_port
        localparam bit PRESENT = (p == DIR_LOCAL)
            || (p == DIR_NORTH && ROW != 0)
            || (p == DIR_SOUTH && ROW != `NOC_NUM_ROWS - 1)
            || (p == DIR_EAST  && COL != `NOC_NUM_COLS - 1)
            || (p == DIR_WEST  && COL != 0);

        if (PRESENT) begin : g_unit
            noc_input_unit #(.ROW(ROW), .COL(COL)) u_input (
                .clk        (clk),
                .rst_n      (rst_n),
                .data       (data_in[p]),
                .dest       (dest_in[p]),
                .is_tail    (is_tail_in[p]),
                .send       (send_in[p]),
                .grant      (grant[p]),
                .head_data  (head_data[p]),
                .head_dest  (head_dest[p]),
                .head_tail  (head_tail[p]),
                .head_valid (head_valid[p]),
                .route_req  (route_req[p]),
                .credit     (credit_out[p])
            );

            noc_output_unit u_output (
                .clk       (clk),
                .rst_n     (rst_n),
                .fire      (out_fire[p]),
                .xbar_data (xbar_data[p]),
                .xbar_dest (xbar_dest[p]),
                .xbar_tail (xbar_tail[p]),
                .credit    (credit_in[p]),
                .data      (data_out[p]),
                .dest      (dest_out[p]),
                .is_tail   (is_tail_out[p]),
                .send      (send_out[p]),
                .ready     (out_ready[p])
            );
        end else begin : g_tie
            // No neighbor on this side
            assign head_data[p]   = '0;
            assign head_dest[p]   = '0;
            assign head_tail[p]   = 1'b0;
            assign head_valid[p]  = 1'b0;
            assign route_req[p]   = '0;
            assign credit_out[p]  = 1'b0;
            assign out_ready[p]   = 1'b0;
            assign data_out[p]    = '0;
            assign dest_out[p]    = '0;
            assign is_tail_out[p] = 1'b0;
            assign send_out[p]    = 1'b0;
        end
    end

    noc_switch_allocator u_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .route_req  (route_req),
        .head_valid (head_valid),
        .head_tail  (head_tail),
        .out_ready  (out_ready),
        .grant      (grant),
        .out_select (out_select),
        .out_fire   (out_fire)
    );

    // Sources never address their own node
    assert property (@(posedge clk) disable iff (!rst_n)
        !(head_valid[DIR_LOCAL] && route_req[DIR_LOCAL][DIR_LOCAL]));

endmodule

// ==== logic/noc_mesh.sv ====
// Mesh network-on-chip
// Grid of XY-routed wormhole routers joined by direct credit-based links,
// with one local injection and ejection port per node
`timescale 1ns/1ps
`include "noc_config.svh"

module noc_mesh
    import noc_flit_pkg::*, noc_route_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  flit_data_t data_in     [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    input  node_id_t   dest_in     [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    input  logic       is_tail_in  [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    input  logic       send_in     [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    output logic       credit_out  [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    output flit_data_t data_out    [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    output node_id_t   dest_out    [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    output logic       is_tail_out [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    output logic       send_out    [`NOC_NUM_ROWS][`NOC_NUM_COLS],
    input  logic       credit_in   [`NOC_NUM_ROWS][`NOC_NUM_COLS]
);

    localparam int ROWS = `NOC_NUM_ROWS;
    localparam int COLS = `NOC_NUM_COLS;
    localparam int N    = `NOC_NUM_PORTS;

    // Router-side ports, last index is the direction
    flit_data_t r_data_in     [ROWS][COLS][N];
    node_id_t   r_dest_in     [ROWS][COLS][N];
    logic       r_is_tail_in  [ROWS][COLS][N];
    logic       r_send_in     [ROWS][COLS][N];
    logic       r_credit_out  [ROWS][COLS][N];
    flit_data_t r_data_out    [ROWS][COLS][N];
    node_id_t   r_dest_out    [ROWS][COLS][N];
    logic       r_is_tail_out [ROWS][COLS][N];
    logic       r_send_out    [ROWS][COLS][N];
    logic       r_credit_in   [ROWS][COLS][N];

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            assign r_data_in[r][c][DIR_LOCAL]    = data_in[r][c];
            assign r_dest_in[r][c][DIR_LOCAL]    = dest_in[r][c];
            assign r_is_tail_in[r][c][DIR_LOCAL] = is_tail_in[r][c];
            assign r_send_in[r][c][DIR_LOCAL]    = send_in[r][c];
            assign r_credit_in[r][c][DIR_LOCAL]  = credit_in[r][c];
            assign credit_out[r][c]  = r_credit_out[r][c][DIR_LOCAL];
            assign data_out[r][c]    = r_data_out[r][c][DIR_LOCAL];
            assign dest_out[r][c]    = r_dest_out[r][c][DIR_LOCAL];
            assign is_tail_out[r][c] = r_is_tail_out[r][c][DIR_LOCAL];
            assign send_out[r][c]    = r_send_out[r][c][DIR_LOCAL];

            // Each input listens to the facing output of its neighbor
            for (genvar d = 1; d < N; d++) begin : g_dir
                localparam int NR = r + int'(d == DIR_SOUTH) - int'(d == DIR_NORTH);
                localparam int NC = c + int'(d == DIR_EAST) - int'(d == DIR_WEST);
                localparam port_dir_e OPP = (d == DIR_NORTH) ? DIR_SOUTH :
                                            (d == DIR_SOUTH) ? DIR_NORTH :
                                            (d == DIR_EAST)  ? DIR_WEST  : DIR_EAST;

                if (NR >= 0 && NR < ROWS && NC >= 0 && NC < COLS) begin : g_link
                    assign r_data_in[r][c][d]    = r_data_out[NR][NC][OPP];
                    assign r_dest_in[r][c][d]    = r_dest_out[NR][NC][OPP];
                    assign r_is_tail_in[r][c][d] = r_is_tail_out[NR][NC][OPP];
                    assign r_send_in[r][c][d]    = r_send_out[NR][NC][OPP];
                    assign r_credit_in[r][c][d]  = r_credit_out[NR][NC][OPP];
                end else begin : g_edge
                    assign r_data_in[r][c][d]    = '0;
                    assign r_dest_in[r][c][d]    = '0;
                    assign r_is_tail_in[r][c][d] = 1'b0;
                    assign r_send_in[r][c][d]    = 1'b0;
                    assign r_credit_in[r][c][d]  = 1'b0;
                end
            end

            noc_router #(.ROW(r), .COL(c)) u_router (
                .clk         (clk),
                .rst_n       (rst_n),
                .data_in     (r_data_in[r][c]),
                .dest_in     (r_dest_in[r][c]),
                .is_tail_in  (r_is_tail_in[r][c]),
                .send_in     (r_send_in[r][c]),
                .credit_out  (r_credit_out[r][c]),
                .data_out    (r_data_out[r][c]),
                .dest_out    (r_dest_out[r][c]),
                .is_tail_out (r_is_tail_out[r][c]),
                .send_out    (r_send_out[r][c]),
                .credit_in   (r_credit_in[r][c])
            );
        end
    end

endmodule

// ==== verif/noc_mesh_tb.sv ====
// Testbench for the 2x2 mesh NoC
// Credit-counting traffic sources and randomly delayed sinks at every node.
// Concurrent assertions check delivery, packet order and credit flow.
`timescale 1ns/1ps
`include "noc_config.svh"

module noc_mesh_tb
    import noc_flit_pkg::*;
();

    localparam int ROWS        = `NOC_NUM_ROWS;
    localparam int COLS        = `NOC_NUM_COLS;
    localparam int NODES       = ROWS * COLS;
    localparam int DEPTH       = `NOC_BUFFER_DEPTH;
    localparam int MAX_FLITS   = 128;
    localparam int DRAIN_LIMIT = 2000;

    logic       clk;
    logic       rst_n;
    flit_data_t data_in     [ROWS][COLS];
    node_id_t   dest_in     [ROWS][COLS];
    logic       is_tail_in  [ROWS][COLS];
    logic       send_in     [ROWS][COLS];
    logic       credit_out  [ROWS][COLS];
    flit_data_t data_out    [ROWS][COLS];
    node_id_t   dest_out    [ROWS][COLS];
    logic       is_tail_out [ROWS][COLS];
    logic       send_out    [ROWS][COLS];
    logic       credit_in   [ROWS][COLS];

    // Traffic queued by the main sequence
    flit_data_t tx_data [NODES][MAX_FLITS];
    node_id_t   tx_dest [NODES][MAX_FLITS];
    logic       tx_tail [NODES][MAX_FLITS];
    int         tx_len  [NODES];
    int         tx_to   [NODES];
    int         seq_ctr [NODES][NODES];
    logic       hold    [NODES];
    int         seed;

    // Source and sink state
    int   tx_pos      [NODES];
    int   src_credits [NODES];
    int   owed        [NODES];
    int   sink_delay  [NODES];
    logic injected;

    // Scoreboard state with exp_seq indexed by source then destination
    int   rx_count   [NODES];
    logic in_pkt     [NODES];
    int   cur_src    [NODES];
    int   exp_idx    [NODES];
    int   exp_seq    [NODES][NODES];
    int   held_sends [NODES];
    logic any_out;

    int errors;
    int last_errors;
    int tests;

    noc_mesh u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .data_in     (data_in),
        .dest_in     (dest_in),
        .is_tail_in  (is_tail_in),
        .send_in     (send_in),
        .credit_out  (credit_out),
        .data_out    (data_out),
        .dest_out    (dest_out),
        .is_tail_out (is_tail_out),
        .send_out    (send_out),
        .credit_in   (credit_in)
    );

    always begin
        clk = 1'b0;
        #5;
        clk = 1'b1;
        #5;
    end

    // Payload holds source, packet length, sequence number and flit index
    function automatic flit_data_t make_flit(int src, int len, int seq, int idx);
        return {4'(src), 4'(len), 16'(seq), 8'(idx)};
    endfunction

    function automatic int flit_src(flit_data_t d);
        return int'(d[31:28]) % NODES;
    endfunction

    function automatic int flit_len(flit_data_t d);
        return int'(d[27:24]);
    endfunction

    function automatic int flit_seq(flit_data_t d);
        return int'(d[23:8]);
    endfunction

    function automatic int flit_idx(flit_data_t d);
        return int'(d[7:0]);
    endfunction

    function automatic void note_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors = errors + 1;
    endfunction

    task automatic step_source(input int n);
        int r;
        int c;
        r = n / COLS;
        c = n % COLS;
        if (credit_out[r][c]) begin
            src_credits[n] = src_credits[n] + 1;
        end
        if (tx_pos[n] < tx_len[n] && src_credits[n] > 0) begin
            data_in[r][c]    = tx_data[n][tx_pos[n]];
            dest_in[r][c]    = tx_dest[n][tx_pos[n]];
            is_tail_in[r][c] = tx_tail[n][tx_pos[n]];
            send_in[r][c]    = 1'b1;
            src_credits[n]   = src_credits[n] - 1;
            tx_pos[n]        = tx_pos[n] + 1;
            injected         = 1'b1;
        end else begin
            send_in[r][c] = 1'b0;
        end
    endtask

    task automatic step_sink(input int n);
        int r;
        int c;
        r = n / COLS;
        c = n % COLS;
        if (send_out[r][c]) begin
            owed[n] = owed[n] + 1;
        end
        if (!hold[n] && owed[n] > 0 && sink_delay[n] == 0) begin
            credit_in[r][c] = 1'b1;
            owed[n]         = owed[n] - 1;
            sink_delay[n]   = int'($unsigned($random(seed)) % 4);
        end else begin
            credit_in[r][c] = 1'b0;
            if (sink_delay[n] > 0) begin
                sink_delay[n] = sink_delay[n] - 1;
            end
        end
    endtask

    // Drives every DUT input except clk and rst_n
    initial begin
        for (int n = 0; n < NODES; n++) begin
            data_in[n / COLS][n % COLS]    = '0;
            dest_in[n / COLS][n % COLS]    = '0;
            is_tail_in[n / COLS][n % COLS] = 1'b0;
            send_in[n / COLS][n % COLS]    = 1'b0;
            credit_in[n / COLS][n % COLS]  = 1'b0;
            tx_pos[n]      = 0;
            src_credits[n] = DEPTH;
            owed[n]        = 0;
            sink_delay[n]  = 0;
        end
        injected = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n) begin
                for (int n = 0; n < NODES; n++) begin
                    step_source(n);
                    step_sink(n);
                end
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        int n;
        if (!rst_n) begin
            for (int k = 0; k < NODES; k++) begin
                rx_count[k]   <= 0;
                in_pkt[k]     <= 1'b0;
                cur_src[k]    <= 0;
                exp_idx[k]    <= 0;
                held_sends[k] <= 0;
                for (int s = 0; s < NODES; s++) begin
                    exp_seq[s][k] <= 0;
                end
            end
        end else begin
            for (int r = 0; r < ROWS; r++) begin
                for (int c = 0; c < COLS; c++) begin
                    n = r * COLS + c;
                    if (!hold[n]) begin
                        held_sends[n] <= 0;
                    end else if (send_out[r][c]) begin
                        held_sends[n] <= held_sends[n] + 1;
                    end
                    if (send_out[r][c]) begin
                        rx_count[n] <= rx_count[n] + 1;
                        in_pkt[n]   <= !is_tail_out[r][c];
                        cur_src[n]  <= flit_src(data_out[r][c]);
                        exp_idx[n]  <= flit_idx(data_out[r][c]) + 1;
                        if (is_tail_out[r][c]) begin
                            exp_seq[flit_src(data_out[r][c])][n] <=
                                flit_seq(data_out[r][c]) + 1;
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        any_out = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                any_out = any_out | send_out[r][c] | credit_out[r][c];
            end
        end
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n) !injected |-> !any_out)
        else note_error("output activity before any flit was injected");

    for (genvar r = 0; r < ROWS; r++) begin : g_row
        for (genvar c = 0; c < COLS; c++) begin : g_col
            localparam int NODE = r * COLS + c;

            a_dest: assert property (@(posedge clk) disable iff (!rst_n)
                send_out[r][c] |-> dest_out[r][c] == node_id_t'(NODE))
                else note_error($sformatf("node %0d ejected a flit for node %0d",
                    NODE, dest_out[r][c]));

            a_tail: assert property (@(posedge clk) disable iff (!rst_n)
                send_out[r][c] |-> is_tail_out[r][c] ==
                    (flit_idx(data_out[r][c]) == flit_len(data_out[r][c]) - 1))
                else note_error($sformatf("node %0d tail flag on wrong flit", NODE));

            // Body flits continue the open packet
            a_body: assert property (@(posedge clk) disable iff (!rst_n)
                send_out[r][c] && in_pkt[NODE] |->
                    flit_src(data_out[r][c]) == cur_src[NODE] &&
                    flit_idx(data_out[r][c]) == exp_idx[NODE])
                else note_error($sformatf("node %0d packet interleaved or flit skipped", NODE));

            a_head: assert property (@(posedge clk) disable iff (!rst_n)
                send_out[r][c] && !in_pkt[NODE] |->
                    flit_idx(data_out[r][c]) == 0 &&
                    flit_seq(data_out[r][c]) == exp_seq[flit_src(data_out[r][c])][NODE])
                else note_error($sformatf("node %0d head out of sequence, seq %0d",
                    NODE, flit_seq(data_out[r][c])));

            a_hold: assert property (@(posedge clk) disable iff (!rst_n)
                hold[NODE] |-> held_sends[NODE] <= DEPTH)
                else note_error($sformatf("node %0d sent past its credits", NODE));

            a_credit: assert property (@(posedge clk) disable iff (!rst_n)
                src_credits[NODE] <= DEPTH)
                else note_error($sformatf("node %0d source credits at %0d",
                    NODE, src_credits[NODE]));
        end
    end

    task automatic queue_packets(input int src, input int count, input int fixed_dst);
        int dst;
        int len;
        int seq;
        for (int p = 0; p < count; p++) begin
            if (fixed_dst < 0) begin
                dst = (src + 1 + int'($unsigned($random(seed)) % 3)) % NODES;
            end else begin
                dst = fixed_dst;
            end
            len = 1 + int'($unsigned($random(seed)) % 4);
            seq = seq_ctr[src][dst];
            seq_ctr[src][dst] = seq + 1;
            for (int i = 0; i < len; i++) begin
                tx_data[src][tx_len[src]] = make_flit(src, len, seq, i);
                tx_dest[src][tx_len[src]] = node_id_t'(dst);
                tx_tail[src][tx_len[src]] = (i == len - 1);
                tx_len[src] = tx_len[src] + 1;
            end
            tx_to[dst] = tx_to[dst] + len;
        end
    endtask

    // Every source done and every sink has at least the flits addressed to it
    function automatic logic all_drained();
        for (int n = 0; n < NODES; n++) begin
            if (tx_pos[n] < tx_len[n] || rx_count[n] < tx_to[n] || owed[n] != 0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (!all_drained() && cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!all_drained()) begin
            $display("Timeout: %s did not drain within %0d cycles", what, DRAIN_LIMIT);
            errors = errors + 1;
        end
    endtask

    task automatic finish_test(input string name);
        tests = tests + 1;
        $display("test %0d %s: %0d errors", tests, name, errors - last_errors);
        last_errors = errors;
    endtask

    initial begin
        seed        = 66;
        errors      = 0;
        last_errors = 0;
        tests       = 0;
        rst_n       = 1'b0;
        for (int n = 0; n < NODES; n++) begin
            hold[n]   = 1'b0;
            tx_len[n] = 0;
            tx_to[n]  = 0;
            for (int d = 0; d < NODES; d++) begin
                seq_ctr[n][d] = 0;
            end
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        repeat (20) @(negedge clk);
        finish_test("reset and idle");

        for (int s = 0; s < NODES; s++) begin
            queue_packets(s, 12, -1);
        end
        wait_drained("random traffic");
        finish_test("random traffic");

        // Last node stops returning credits while the others flood it
        @(negedge clk);
        hold[NODES-1] = 1'b1;
        for (int s = 0; s < NODES - 1; s++) begin
            queue_packets(s, 6, NODES - 1);
        end
        repeat (60) @(negedge clk);
        hold[NODES-1] = 1'b0;
        wait_drained("back-pressure traffic");
        finish_test("back-pressure at one sink");

        for (int n = 0; n < NODES; n++) begin
            assert (rx_count[n] == tx_to[n])
                else note_error($sformatf("node %0d received %0d of %0d flits",
                    n, rx_count[n], tx_to[n]));
            assert (src_credits[n] == DEPTH)
                else note_error($sformatf("node %0d ended with %0d credits", n, src_credits[n]));
        end
        finish_test("flit counts and credit return");

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
logic/noc_flit_pkg.sv
logic/noc_route_pkg.sv
logic/noc_input_unit.sv
logic/noc_switch_allocator.sv
logic/noc_output_unit.sv
logic/noc_router.sv
logic/noc_mesh.sv
verif/noc_mesh_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the mesh NoC testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module noc_mesh_tb -f build.f -o noc_mesh_sim

output=$(./obj_dir/noc_mesh_sim) || true
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
